/* tsc_cpu.f */
source/tsc_pkg.sv
source/pc_unit.sv
source/control_unit.sv
source/register_file.sv
source/alu.sv
source/datapath.sv
source/tsc_cpu.sv
testbench/tb_clock_gen.sv
testbench/tsc_cpu_properties.sv
testbench/tsc_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tsc_cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tsc_cpu.f --top-module tsc_cpu_tb \
	-Mdir obj_dir -o tsc_cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build did not succeed, see build.log"
	exit 1
fi

./obj_dir/tsc_cpu_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "sim failed" sim.log; then
	exit 1
fi
if ! grep -q "sim passed" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

/* testbench/tsc_cpu_tb.sv */
`timescale 1ns/1ps

module tsc_cpu_tb import tsc_pkg::*;;

	localparam int num_rows = 6;
	localparam int cycle_limit = num_rows * 80 + 20;

	logic        clk;
	logic        rst_n;
	logic        reset_req;
	logic        load_mem;
	logic        mem_ready;
	logic        read_m1;
	logic [15:0] address1;
	logic [15:0] data1;
	logic        read_m2;
	logic        write_m2;
	logic [15:0] address2;
	logic [15:0] store_data2;
	logic [15:0] data2;
	logic [15:0] num_inst;
	logic [15:0] output_port;
	logic        is_halted;
	logic [15:0] imem [256];
	logic [15:0] dmem [256];

	// program table with hand-worked expected results
	string       test_name [num_rows];
	int          prog_len [num_rows];
	logic [15:0] prog [num_rows][12];
	logic [15:0] init_data [num_rows][3];
	logic [15:0] exp_port [num_rows];
	logic [15:0] exp_count [num_rows];
	logic [7:0]  exp_addr [num_rows];
	logic [15:0] exp_word [num_rows];

	int row;
	int cycles;
	int value_errors;
	int timeouts;

	tb_clock_gen clock_gen_i (
		.reset_req(reset_req),
		.clk(clk),
		.rst_n(rst_n)
	);

	tsc_cpu #(.WORD_SIZE(16)) tsc_cpu_i (
		.clk(clk),
		.rst_n(rst_n),
		.read_m1(read_m1),
		.address1(address1),
		.data1(data1),
		.read_m2(read_m2),
		.write_m2(write_m2),
		.address2(address2),
		.store_data2(store_data2),
		.data2(data2),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	bind datapath tsc_cpu_properties props_i (
		.clk(clk),
		.rst_n(rst_n),
		.read_m1(read_m1),
		.read_m2(read_m2),
		.write_m2(write_m2),
		.is_halted(is_halted),
		.num_inst(num_inst)
	);

	// both memories answer in the same cycle while their read strobe is high
	assign data1 = (mem_ready && read_m1) ? imem[address1[7:0]] : 16'h0000;
	assign data2 = (mem_ready && read_m2) ? dmem[address2[7:0]] : 16'h0000;

	// unused imem words decode as hlt and the dmem fill follows the address
	always @(posedge clk) begin
		if (load_mem) begin
			for (int i = 0; i < 256; i++) begin
				if (i < prog_len[row]) begin
					imem[i] <= prog[row][i];
				end else begin
					imem[i] <= {4'hE, 4'h0, i[7:0]};
				end
				if (i < 3) begin
					dmem[i] <= init_data[row][i];
				end else begin
					dmem[i] <= {i[7:0], ~i[7:0]};
				end
			end
			mem_ready <= 1'b1;
		end else if (write_m2) begin
			dmem[address2[7:0]] <= store_data2;
		end
	end

	function automatic logic [15:0] rtype(input logic [1:0] rs, input logic [1:0] rt,
		input logic [1:0] rd, input logic [5:0] funct);
		return {4'hF, rs, rt, rd, funct};
	endfunction

	function automatic logic [15:0] itype(input opcode_e op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] jtype(input opcode_e op, input logic [11:0] tgt);
		return {op, tgt};
	endfunction

	task automatic set_row(input int r, input string name, input logic [15:0] port,
		input logic [15:0] count, input logic [7:0] addr, input logic [15:0] word);
		test_name[r] = name;
		exp_port[r] = port;
		exp_count[r] = count;
		exp_addr[r] = addr;
		exp_word[r] = word;
		init_data[r][0] = 16'h0100;
		init_data[r][1] = 16'h0007;
		init_data[r][2] = 16'hbeef;
	endtask

	task automatic build_table();
		// 0x1234 + 0xfff5 = 0x1229, & 0xfff5 = 0x1221, | 0x1234 = 0x1235, - 0xfff5 = 0x1240
		set_row(0, "alu_imm", 16'h1240, 16'd9, 8'd2, 16'hbeef);
		prog[0] = '{itype(LHI, 2'd0, 2'd1, 8'h12), itype(ORI, 2'd1, 2'd1, 8'h34),
			itype(ADI, 2'd0, 2'd2, 8'hf5), rtype(2'd1, 2'd2, 2'd3, 6'd0),
			rtype(2'd3, 2'd2, 2'd3, 6'd2), rtype(2'd3, 2'd1, 2'd3, 6'd3),
			rtype(2'd3, 2'd2, 2'd3, 6'd1), rtype(2'd3, 2'd0, 2'd0, 6'd28),
			16'he000, 16'h0, 16'h0, 16'h0};
		prog_len[0] = 9;
		// 5 + 3 - 2 + 16
		set_row(1, "raw_hazard", 16'h0016, 16'd6, 8'd0, 16'h0100);
		prog[1] = '{itype(ADI, 2'd0, 2'd1, 8'h05), itype(ADI, 2'd1, 2'd1, 8'h03),
			itype(ADI, 2'd1, 2'd1, 8'hfe), itype(ADI, 2'd1, 2'd1, 8'h10),
			rtype(2'd1, 2'd0, 2'd0, 6'd28), 16'he000,
			16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		prog_len[1] = 6;
		// mem[5] = mem[0] + mem[1] is read back and shown
		set_row(2, "load_store", 16'h0107, 16'd7, 8'd5, 16'h0107);
		prog[2] = '{itype(LWD, 2'd0, 2'd1, 8'h00), itype(LWD, 2'd0, 2'd2, 8'h01),
			rtype(2'd1, 2'd2, 2'd3, 6'd0), itype(SWD, 2'd0, 2'd3, 8'h05),
			itype(LWD, 2'd0, 2'd1, 8'h05), rtype(2'd1, 2'd0, 2'd0, 6'd28),
			16'he000, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		prog_len[2] = 7;
		// beq skips the +0x40 and bne falls through to the +0x10
		set_row(3, "branches", 16'h0013, 16'd7, 8'd1, 16'h0007);
		prog[3] = '{itype(ADI, 2'd0, 2'd1, 8'h03), itype(ADI, 2'd0, 2'd2, 8'h03),
			itype(BEQ, 2'd1, 2'd2, 8'h01), itype(ADI, 2'd1, 2'd1, 8'h40),
			itype(BNE, 2'd1, 2'd2, 8'h01), itype(ADI, 2'd1, 2'd1, 8'h10),
			rtype(2'd1, 2'd0, 2'd0, 6'd28), 16'he000,
			16'h0, 16'h0, 16'h0, 16'h0};
		prog_len[3] = 8;
		// jal at 0 links 1 into r2 and jmp skips a wwd of r3
		set_row(4, "jump_link", 16'h0001, 16'd4, 8'd2, 16'hbeef);
		prog[4] = '{jtype(JAL, 12'd3), itype(ADI, 2'd2, 2'd2, 8'h40), 16'he000,
			rtype(2'd2, 2'd0, 2'd0, 6'd28), jtype(JMP, 12'd6),
			rtype(2'd3, 2'd0, 2'd0, 6'd28), 16'he000,
			16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		prog_len[4] = 7;
		set_row(5, "halt", 16'h0009, 16'd3, 8'd0, 16'h0100);
		prog[5] = '{itype(ADI, 2'd0, 2'd1, 8'h09), rtype(2'd1, 2'd0, 2'd0, 6'd28),
			16'he000, itype(ADI, 2'd1, 2'd1, 8'h01), rtype(2'd1, 2'd0, 2'd0, 6'd28),
			16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		prog_len[5] = 5;
	endtask

	task automatic check_value(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			value_errors++;
			$display("Error: %s %s expected %h actual %h", test_name[row], what,
				expected, actual);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			timeouts++;
			$display("timeout in %s, the processor never halted", test_name[row]);
			finish_run();
		end
	end

	initial begin
		reset_req = 1'b1;
		load_mem = 1'b0;
		mem_ready = 1'b0;
		row = 0;
		cycles = 0;
		value_errors = 0;
		timeouts = 0;
		build_table();
		for (int r = 0; r < num_rows; r++) begin
			@(posedge clk);
			#1;
			row = r;
			reset_req = 1'b1;
			load_mem = 1'b1;
			@(posedge clk);
			#1;
			reset_req = 1'b0;
			load_mem = 1'b0;
			@(negedge clk);
			while (!rst_n) begin
				@(negedge clk);
			end
			while (!is_halted) begin
				@(negedge clk);
			end
			// nothing after hlt may retire
			repeat (10) @(negedge clk);
			if (!is_halted) begin
				value_errors++;
				$display("Error: %s is_halted dropped after the halt", test_name[r]);
			end
			check_value("output_port", exp_port[r], output_port);
			check_value("num_inst", exp_count[r], num_inst);
			check_value("data word", exp_word[r], dmem[exp_addr[r]]);
		end
		finish_run();
	end

endmodule

/* testbench/tsc_cpu_properties.sv */
`timescale 1ns/1ps

module tsc_cpu_properties (
	input logic        clk,
	input logic        rst_n,
	input logic        read_m1,
	input logic        read_m2,
	input logic        write_m2,
	input logic        is_halted,
	input logic [15:0] num_inst
);

	// data port is either a read or a write
	assert property (@(posedge clk) disable iff (!rst_n) !(read_m2 && write_m2))
		else $error("read_m2 and write_m2 high together");

	// halt is sticky
	assert property (@(posedge clk) disable iff (!rst_n) $past(is_halted) |-> is_halted)
		else $error("is_halted fell without reset");

	assert property (@(posedge clk) disable iff (!rst_n)
		(num_inst - $past(num_inst)) <= 16'd1)
		else $error("num_inst rose by more than one");

	// first cycle out of reset has no memory traffic
	assert property (@(posedge clk) $rose(rst_n) |-> !read_m1 && !read_m2 && !write_m2)
		else $error("memory strobe high right after reset");

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	input  logic reset_req,
	output logic clk,
	output logic rst_n
);

	logic [2:0] cnt;
	logic       req;

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		cnt = 3'd0;
	end

	// 4 ns period
	always #2 clk = ~clk;

	// rst_n held low for four edges after a request, changed 1 ns after the edge
	always @(posedge clk) begin
		req = reset_req;
		#1;
		if (req) begin
			cnt = 3'd0;
		end else if (cnt != 3'd4) begin
			cnt = cnt + 3'd1;
		end
		rst_n = (cnt == 3'd4);
	end

endmodule

/* source/tsc_cpu.sv */
`timescale 1ns/1ps

module tsc_cpu import tsc_pkg::*; #(
	parameter int WORD_SIZE = word_size
) (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic                 read_m1,
	output logic [WORD_SIZE-1:0] address1,
	input  logic [WORD_SIZE-1:0] data1,
	output logic                 read_m2,
	output logic                 write_m2,
	output logic [WORD_SIZE-1:0] address2,
	output logic [WORD_SIZE-1:0] store_data2,
	input  logic [WORD_SIZE-1:0] data2,
	output logic [WORD_SIZE-1:0] num_inst,
	output logic [WORD_SIZE-1:0] output_port,
	output logic                 is_halted
);

	logic [WORD_SIZE-1:0] instr;
	logic                 if_id_valid;
	ctrl_t                ex_ctrl;
	logic                 ex_valid;
	ctrl_t                mem_ctrl;
	logic                 mem_valid;
	logic                 redirect;
	ctrl_t                id_ctrl;
	logic [WORD_SIZE-1:0] id_imm;
	logic                 stall;
	logic                 flush;
	logic                 halt_fetch;

	control_unit control_unit_i (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.if_id_valid(if_id_valid),
		.ex_ctrl(ex_ctrl),
		.ex_valid(ex_valid),
		.mem_ctrl(mem_ctrl),
		.mem_valid(mem_valid),
		.redirect(redirect),
		.id_ctrl(id_ctrl),
		.id_imm(id_imm),
		.stall(stall),
		.flush(flush),
		.halt_fetch(halt_fetch)
	);

	datapath #(.WORD_SIZE(WORD_SIZE)) datapath_i (
		.clk(clk),
		.rst_n(rst_n),
		.id_ctrl(id_ctrl),
		.id_imm(id_imm),
		.stall(stall),
		.flush(flush),
		.halt_fetch(halt_fetch),
		.instr(instr),
		.if_id_valid(if_id_valid),
		.ex_ctrl(ex_ctrl),
		.ex_valid(ex_valid),
		.mem_ctrl(mem_ctrl),
		.mem_valid(mem_valid),
		.redirect(redirect),
		.read_m1(read_m1),
		.address1(address1),
		.data1(data1),
		.read_m2(read_m2),
		.write_m2(write_m2),
		.address2(address2),
		.data2(data2),
		.store_data2(store_data2),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

endmodule

/* source/datapath.sv */
`timescale 1ns/1ps

module datapath import tsc_pkg::*; #(
	parameter int WORD_SIZE = word_size
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  ctrl_t                id_ctrl,
	input  logic [WORD_SIZE-1:0] id_imm,
	input  logic                 stall,
	input  logic                 flush,
	input  logic                 halt_fetch,
	output logic [WORD_SIZE-1:0] instr,
	output logic                 if_id_valid,
	output ctrl_t                ex_ctrl,
	output logic                 ex_valid,
	output ctrl_t                mem_ctrl,
	output logic                 mem_valid,
	output logic                 redirect,
	output logic                 read_m1,
	output logic [WORD_SIZE-1:0] address1,
	input  logic [WORD_SIZE-1:0] data1,
	output logic                 read_m2,
	output logic                 write_m2,
	output logic [WORD_SIZE-1:0] address2,
	input  logic [WORD_SIZE-1:0] data2,
	output logic [WORD_SIZE-1:0] store_data2,
	output logic [WORD_SIZE-1:0] num_inst,
	output logic [WORD_SIZE-1:0] output_port,
	output logic                 is_halted
);

	id_ex_t               id_ex;
	id_ex_t               id_ex_d;
	ex_mem_t              ex_mem;
	ex_mem_t              ex_mem_d;
	mem_wb_t              mem_wb;
	mem_wb_t              mem_wb_d;
	logic [WORD_SIZE-1:0] if_pc_plus1;
	logic [WORD_SIZE-1:0] id_pc;
	logic [WORD_SIZE-1:0] rd_a;
	logic [WORD_SIZE-1:0] rd_b;
	logic [WORD_SIZE-1:0] alu_b;
	logic [WORD_SIZE-1:0] alu_result;
	logic                 alu_equal;
	logic                 branch_taken;
	logic [WORD_SIZE-1:0] target;
	logic                 wb_en;
	logic [WORD_SIZE-1:0] wb_data;

	pc_unit #(.WORD_SIZE(WORD_SIZE)) pc_unit_i (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.flush(flush),
		.halt_fetch(halt_fetch),
		.target(target),
		.data1(data1),
		.read_m1(read_m1),
		.address1(address1),
		.instr(instr),
		.pc_plus1(if_pc_plus1),
		.if_id_valid(if_id_valid)
	);

	register_file #(.WORD_SIZE(WORD_SIZE)) register_file_i (
		.clk(clk),
		.rst_n(rst_n),
		.rs(instr[11:10]),
		.rt(instr[9:8]),
		.wr_en(wb_en),
		.wr_addr(mem_wb.ctrl.dest),
		.wr_data(wb_data),
		.rd_a(rd_a),
		.rd_b(rd_b)
	);

	// id stage, a stall or flush turns the slot into a bubble
	assign id_pc = if_pc_plus1 - 1'b1;
	assign id_ex_d = '{
		valid: if_id_valid && !stall && !flush,
		ctrl: id_ctrl,
		pc_plus1: if_pc_plus1,
		a: rd_a,
		b: rd_b,
		imm: id_imm,
		jump_target: {id_pc[WORD_SIZE-1:12], instr[11:0]}
	};

	// ex stage
	assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.b;

	alu #(.WORD_SIZE(WORD_SIZE)) alu_i (
		.op(id_ex.ctrl.alu_op),
		.a(id_ex.a),
		.b(alu_b),
		.result(alu_result),
		.equal(alu_equal)
	);

	assign branch_taken = (id_ex.ctrl.is_branch_eq && alu_equal) ||
		(id_ex.ctrl.is_branch_ne && !alu_equal);
	assign redirect = id_ex.valid && (id_ex.ctrl.is_jump || branch_taken);
	assign target = id_ex.ctrl.is_jump ? id_ex.jump_target : id_ex.pc_plus1 + id_ex.imm;

	assign ex_mem_d = '{
		valid: id_ex.valid,
		ctrl: id_ex.ctrl,
		pc_plus1: id_ex.pc_plus1,
		alu_out: alu_result,
		store_data: id_ex.b
	};

	// mem stage, data memory answers in the same cycle
	assign read_m2 = ex_mem.valid && ex_mem.ctrl.mem_read;
	assign write_m2 = ex_mem.valid && ex_mem.ctrl.mem_write;
	assign address2 = ex_mem.alu_out;
	assign store_data2 = ex_mem.store_data;

	assign mem_wb_d = '{
		valid: ex_mem.valid,
		ctrl: ex_mem.ctrl,
		pc_plus1: ex_mem.pc_plus1,
		alu_out: ex_mem.alu_out,
		load_data: data2
	};

	// wb stage
	assign wb_en = mem_wb.valid && mem_wb.ctrl.reg_write;
	assign wb_data = mem_wb.ctrl.pc_to_reg ? mem_wb.pc_plus1 :
		mem_wb.ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.alu_out;

	assign ex_ctrl = id_ex.ctrl;
	assign ex_valid = id_ex.valid;
	assign mem_ctrl = ex_mem.ctrl;
	assign mem_valid = ex_mem.valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.valid <= 1'b0;
			ex_mem.valid <= 1'b0;
			mem_wb.valid <= 1'b0;
		end else begin
			id_ex <= id_ex_d;
			ex_mem <= ex_mem_d;
			mem_wb <= mem_wb_d;
		end
	end

	// retire counter, wwd port and sticky halt
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			num_inst <= '0;
			output_port <= '0;
			is_halted <= 1'b0;
		end else if (mem_wb.valid) begin
			num_inst <= num_inst + 1'b1;
			if (mem_wb.ctrl.is_wwd) begin
				output_port <= mem_wb.alu_out;
			end
			if (mem_wb.ctrl.is_halt) begin
				is_halted <= 1'b1;
			end
		end
	end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu import tsc_pkg::*; #(
	parameter int WORD_SIZE = word_size
) (
	input  alu_op_e              op,
	input  logic [WORD_SIZE-1:0] a,
	input  logic [WORD_SIZE-1:0] b,
	output logic [WORD_SIZE-1:0] result,
	output logic                 equal
);

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = a + b;
			end
			ALU_SUB: begin
				result = a - b;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			// low byte of the immediate moves to the top
			ALU_LHI: begin
				result = {b[7:0], {(WORD_SIZE-8){1'b0}}};
			end
			// wwd carries operand a to write-back
			ALU_PASS_A: begin
				result = a;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// branch compare on the raw register operands
	assign equal = (a == b);

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file import tsc_pkg::*; #(
	parameter int WORD_SIZE = word_size
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [1:0]           rs,
	input  logic [1:0]           rt,
	input  logic                 wr_en,
	input  logic [1:0]           wr_addr,
	input  logic [WORD_SIZE-1:0] wr_data,
	output logic [WORD_SIZE-1:0] rd_a,
	output logic [WORD_SIZE-1:0] rd_b
);

	logic [WORD_SIZE-1:0] regs [4];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rd_a = (wr_en && (wr_addr == rs)) ? wr_data : regs[rs];
	assign rd_b = (wr_en && (wr_addr == rt)) ? wr_data : regs[rt];

endmodule

/* source/control_unit.sv */
`timescale 1ns/1ps

module control_unit import tsc_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [word_size-1:0] instr,
	input  logic                 if_id_valid,
	input  ctrl_t                ex_ctrl,
	input  logic                 ex_valid,
	input  ctrl_t                mem_ctrl,
	input  logic                 mem_valid,
	input  logic                 redirect,
	output ctrl_t                id_ctrl,
	output logic [word_size-1:0] id_imm,
	output logic                 stall,
	output logic                 flush,
	output logic                 halt_fetch
);

	opcode_e    opcode;
	funct_e     funct;
	logic [1:0] rs;
	logic [1:0] rt;
	logic [1:0] rd;
	logic [7:0] imm8;
	logic       uses_rs;
	logic       uses_rt;
	logic       id_halt;
	logic       halt_q;

	assign opcode = opcode_e'(instr[15:12]);
	assign funct = funct_e'(instr[5:0]);
	assign rs = instr[11:10];
	assign rt = instr[9:8];
	assign rd = instr[7:6];
	assign imm8 = instr[7:0];

	// true when an older instruction still has to write r
	function automatic logic pending(input ctrl_t c, input logic v, input logic [1:0] r);
		return v && c.reg_write && (c.dest == r);
	endfunction

	always_comb begin
		id_ctrl = '0;
		id_imm = {{(word_size-8){imm8[7]}}, imm8};
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		case (opcode)
			R_TYPE: begin
				id_ctrl.dest = rd;
				uses_rs = 1'b1;
				case (funct)
					F_ADD, F_SUB, F_AND, F_ORR: begin
						uses_rt = 1'b1;
						id_ctrl.reg_write = 1'b1;
						case (funct)
							F_SUB: id_ctrl.alu_op = ALU_SUB;
							F_AND: id_ctrl.alu_op = ALU_AND;
							F_ORR: id_ctrl.alu_op = ALU_OR;
							default: id_ctrl.alu_op = ALU_ADD;
						endcase
					end
					F_WWD: begin
						id_ctrl.alu_op = ALU_PASS_A;
						id_ctrl.is_wwd = 1'b1;
					end
					// unknown funct behaves as a nop
					default: uses_rs = 1'b0;
				endcase
			end
			ADI, ORI, LHI, LWD: begin
				id_ctrl.alu_src_imm = 1'b1;
				id_ctrl.reg_write = 1'b1;
				id_ctrl.dest = rt;
				uses_rs = (opcode != LHI);
				if (opcode == ORI) begin
					id_ctrl.alu_op = ALU_OR;
					id_imm = {{(word_size-8){1'b0}}, imm8};
				end else if (opcode == LHI) begin
					id_ctrl.alu_op = ALU_LHI;
				end
				id_ctrl.mem_read = (opcode == LWD);
				id_ctrl.mem_to_reg = (opcode == LWD);
			end
			SWD: begin
				id_ctrl.alu_src_imm = 1'b1;
				id_ctrl.mem_write = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			BNE, BEQ: begin
				id_ctrl.alu_op = ALU_SUB;
				id_ctrl.is_branch_eq = (opcode == BEQ);
				id_ctrl.is_branch_ne = (opcode == BNE);
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			JMP: id_ctrl.is_jump = 1'b1;
			JAL: begin
				id_ctrl.is_jump = 1'b1;
				id_ctrl.reg_write = 1'b1;
				id_ctrl.pc_to_reg = 1'b1;
				id_ctrl.dest = 2'd2;
			end
			HLT: id_ctrl.is_halt = 1'b1;
			default: id_ctrl = '0;
		endcase
	end

	// mem/wb writers are covered by the register file bypass
	assign stall = if_id_valid &&
		((uses_rs && (pending(ex_ctrl, ex_valid, rs) || pending(mem_ctrl, mem_valid, rs))) ||
		(uses_rt && (pending(ex_ctrl, ex_valid, rt) || pending(mem_ctrl, mem_valid, rt))));

	assign flush = redirect;

	assign id_halt = if_id_valid && (opcode == HLT);
	assign halt_fetch = halt_q || (id_halt && !flush);

	// once hlt passes decode, fetch stays frozen until reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halt_q <= 1'b0;
		end else if (id_halt && !flush) begin
			halt_q <= 1'b1;
		end
	end

endmodule

/* source/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import tsc_pkg::*; #(
	parameter int WORD_SIZE = word_size
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,
	input  logic                 flush,
	input  logic                 halt_fetch,
	input  logic [WORD_SIZE-1:0] target,
	input  logic [WORD_SIZE-1:0] data1,
	output logic                 read_m1,
	output logic [WORD_SIZE-1:0] address1,
	output logic [WORD_SIZE-1:0] instr,
	output logic [WORD_SIZE-1:0] pc_plus1,
	output logic                 if_id_valid
);

	logic [WORD_SIZE-1:0] pc;
	logic                 fetch_en;

	assign read_m1 = fetch_en && !halt_fetch;
	assign address1 = pc;

	// fetching starts the cycle after reset is released
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_en <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
		end
	end

	// redirect wins over stall, stall over normal stepping
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			if_id_valid <= 1'b0;
		end else if (flush) begin
			pc <= target;
			if_id_valid <= 1'b0;
		end else if (!stall) begin
			if (read_m1) begin
				pc <= pc + 1'b1;
			end
			if_id_valid <= read_m1;
		end
	end

	// if/id payload
	always_ff @(posedge clk) begin
		if (read_m1 && !stall && !flush) begin
			instr <= data1;
			pc_plus1 <= pc + 1'b1;
		end
	end

endmodule

/* source/tsc_pkg.sv */
package tsc_pkg;

	// data and address width
	localparam int word_size = 16;

	// instruction opcodes, bits 15:12
	typedef enum logic [3:0] {
		BNE    = 4'd0,
		BEQ    = 4'd1,
		ADI    = 4'd4,
		ORI    = 4'd5,
		LHI    = 4'd6,
		LWD    = 4'd7,
		SWD    = 4'd8,
		JMP    = 4'd9,
		JAL    = 4'd10,
		HLT    = 4'd14,
		R_TYPE = 4'd15
	} opcode_e;

	// r-type function field, bits 5:0
	typedef enum logic [5:0] {
		F_ADD = 6'd0,
		F_SUB = 6'd1,
		F_AND = 6'd2,
		F_ORR = 6'd3,
		F_WWD = 6'd28
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_LHI    = 3'd4,
		ALU_PASS_A = 3'd5
	} alu_op_e;

	// decoded control of one instruction
	typedef struct packed {
		alu_op_e    alu_op;
		logic       alu_src_imm;
		logic       mem_read;
		logic       mem_write;
		logic       reg_write;
		logic [1:0] dest;
		logic       mem_to_reg;
		logic       pc_to_reg;
		logic       is_branch_eq;
		logic       is_branch_ne;
		logic       is_jump;
		logic       is_wwd;
		logic       is_halt;
	} ctrl_t;

	typedef struct packed {
		logic                 valid;
		ctrl_t                ctrl;
		logic [word_size-1:0] pc_plus1;
		logic [word_size-1:0] a;
		logic [word_size-1:0] b;
		logic [word_size-1:0] imm;
		logic [word_size-1:0] jump_target;
	} id_ex_t;

	typedef struct packed {
		logic                 valid;
		ctrl_t                ctrl;
		logic [word_size-1:0] pc_plus1;
		logic [word_size-1:0] alu_out;
		logic [word_size-1:0] store_data;
	} ex_mem_t;

	typedef struct packed {
		logic                 valid;
		ctrl_t                ctrl;
		logic [word_size-1:0] pc_plus1;
		logic [word_size-1:0] alu_out;
		logic [word_size-1:0] load_data;
	} mem_wb_t;

endpackage
